/* Makefile */
# Verilator build and run of the datapath testbench

TOP := z80_datapath_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f build.f

# the run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

/* build.f */
source/z80_alu_pkg.sv
source/z80_bus_pkg.sv
source/z80_regfile.sv
source/z80_alu.sv
source/z80_acc_flags.sv
source/z80_datapath.sv
dv/z80_datapath_assert.sv
dv/z80_datapath_tb.sv

/* dv/z80_datapath_assert.sv */
module z80_datapath_assert
  import z80_alu_pkg::*;
  import z80_bus_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input dp_ctrl_t ctrl,
  input logic     data_oe,
  input logic     addr_oe,
  input flag_t    flags
);

  timeunit 1ns;
  timeprecision 1ps;

  // FF_KEEP is encoded as zero, so any nonzero override field writes F
  logic force_any;

  // count of property failures seen so far
  int unsigned fail_count = 0;

  assign force_any = (ctrl.flag_force != '0);

  // with no internal source the data pins must stay released
  data_idle_a : assert property (@(posedge clk) disable iff (!arst_n)
    (ctrl.data_src == DS_NONE) |-> !data_oe)
    else begin
      fail_count++;
      $error("data_oe active while no source drives the data bus");
    end

  // the same holds for the address pins
  addr_idle_a : assert property (@(posedge clk) disable iff (!arst_n)
    (ctrl.addr_src == AS_NONE) |-> !addr_oe)
    else begin
      fail_count++;
      $error("addr_oe active while no source drives the address bus");
    end

  // F only moves on a flag load or a forced flag
  flags_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    (!ctrl.ld_f && !force_any) |=> $stable(flags))
    else begin
      fail_count++;
      $error("flags changed without ld_f or a flag force");
    end

endmodule : z80_datapath_assert

/* dv/z80_datapath_tb.sv */
module z80_datapath_tb
  import z80_alu_pkg::*;
  import z80_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // one table row: the control word, the data input and every expected output
  typedef struct packed {
    dp_ctrl_t          ctrl;
    logic [data_w-1:0] din;
    logic [data_w-1:0] dout;
    logic              doe;
    logic [addr_w-1:0] aout;
    logic              aoe;
    flag_t             fl;
  } step_t;

  logic              clk;
  logic              arst_n;
  dp_ctrl_t          ctrl;
  logic [data_w-1:0] data_in;
  logic [data_w-1:0] data_out;
  logic              data_oe;
  logic [addr_w-1:0] addr_out;
  logic              addr_oe;
  flag_t             flags;

  step_t steps[$];

  z80_datapath DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe),
    .flags    (flags)
  );

  bind z80_datapath z80_datapath_assert u_dp_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .ctrl    (ctrl),
    .data_oe (data_oe),
    .addr_oe (addr_oe),
    .flags   (flags)
  );

  // 20 ns clock period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // ---------------------------------------------------------------------------
  // control word builders
  // ---------------------------------------------------------------------------

  // byte load of one register from data_in, the bus is left to the input
  function automatic dp_ctrl_t load_reg(input reg_sel_e r);
    dp_ctrl_t c;
    c           = '0;
    c.reg_wr_en = 1'b1;
    c.reg_wr    = r;
    return c;
  endfunction

  // an internal source drives the data bus, reg_rd picks the register byte
  function automatic dp_ctrl_t read_onto_bus(input data_src_e ds, input reg_sel_e r);
    dp_ctrl_t c;
    c          = '0;
    c.data_src = ds;
    c.reg_rd   = r;
    return c;
  endfunction

  function automatic dp_ctrl_t drive_addr(input addr_src_e as, input pair_sel_e p);
    dp_ctrl_t c;
    c          = '0;
    c.addr_src = as;
    c.pair_rd  = p;
    return c;
  endfunction

  // A op bus byte, with the result written back to A and the flags to F
  function automatic dp_ctrl_t alu_to_a(input alu_op_e op);
    dp_ctrl_t c;
    c            = '0;
    c.alu_op     = op;
    c.ld_a       = 1'b1;
    c.a_from_alu = 1'b1;
    c.ld_f       = 1'b1;
    return c;
  endfunction

  // register on the bus, incremented by the ALU and written back in one cycle
  function automatic dp_ctrl_t inc_reg(input reg_sel_e r);
    dp_ctrl_t c;
    c            = read_onto_bus(DS_REG, r);
    c.alu_op     = ALU_INC;
    c.a_from_alu = 1'b1;
    c.reg_wr_en  = 1'b1;
    c.reg_wr     = r;
    c.ld_f       = 1'b1;
    return c;
  endfunction

  task automatic add_step(input dp_ctrl_t c, input logic [data_w-1:0] din,
                          input logic [data_w-1:0] dout, input logic doe,
                          input logic [addr_w-1:0] aout, input logic aoe, input flag_t fl);
    step_t s;
    s = '{ctrl: c, din: din, dout: dout, doe: doe, aout: aout, aoe: aoe, fl: fl};
    steps.push_back(s);
  endtask

  // ---------------------------------------------------------------------------
  // stimulus table
  // ---------------------------------------------------------------------------

  // expected outputs are those of the cycle the row is applied in, so a load
  // shows up one row later; flag bits are S Z - H - PV N C from bit 7 down
  task automatic build_table();
    dp_ctrl_t c;
    // idle after reset, then A on the bus
    add_step('0, 8'h00, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h00, 1'b1, 16'h0000, 1'b0, 8'h00);
    // byte loads from data_in and their read back
    add_step(load_reg(REG_B), 8'h12, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(load_reg(REG_C), 8'h34, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(load_reg(REG_H), 8'hab, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(load_reg(REG_L), 8'hcd, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_REG, REG_B), 8'h00, 8'h12, 1'b1, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_REG, REG_C), 8'h00, 8'h34, 1'b1, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_REG, REG_H), 8'h00, 8'hab, 1'b1, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_REG, REG_L), 8'h00, 8'hcd, 1'b1, 16'h0000, 1'b0, 8'h00);
    // a pair goes out high byte first
    add_step(drive_addr(AS_PAIR, PAIR_BC), 8'h00, 8'h00, 1'b0, 16'h1234, 1'b1, 8'h00);
    // MAR built bytewise, low byte first
    c = '0;
    c.ld_marl_data = 1'b1;
    add_step(c, 8'h78, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    c = '0;
    c.ld_marh_data = 1'b1;
    add_step(c, 8'h56, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    // MAR on the address bus is written into HL
    c = drive_addr(AS_MAR, PAIR_BC);
    c.pair_wr_en = 1'b1;
    c.pair_wr    = PAIR_HL;
    add_step(c, 8'h00, 8'h00, 1'b0, 16'h5678, 1'b1, 8'h00);
    add_step(drive_addr(AS_PAIR, PAIR_HL), 8'h00, 8'h00, 1'b0, 16'h5678, 1'b1, 8'h00);
    add_step(read_onto_bus(DS_REG, REG_H), 8'h00, 8'h56, 1'b1, 16'h0000, 1'b0, 8'h00);
    // whole-word MAR load from BC on the address bus
    c = drive_addr(AS_PAIR, PAIR_BC);
    c.ld_mar_addr = 1'b1;
    add_step(c, 8'h00, 8'h00, 1'b0, 16'h1234, 1'b1, 8'h00);
    add_step(drive_addr(AS_MAR, PAIR_HL), 8'h00, 8'h00, 1'b0, 16'h1234, 1'b1, 8'h00);
    // plain A load, F untouched
    c = '0;
    c.ld_a = 1'b1;
    add_step(c, 8'h0f, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    // 0f + 01 = 10 with a half carry
    add_step(alu_to_a(ALU_ADD), 8'h01, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h00);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h10, 1'b1, 16'h0000, 1'b0, 8'h10);
    // 10 + f0 = 00 with carry out, so Z and C
    add_step(alu_to_a(ALU_ADD), 8'hf0, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h10);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h00, 1'b1, 16'h0000, 1'b0, 8'h41);
    // 00 + 7f + carry = 80, giving S, H and signed overflow
    add_step(alu_to_a(ALU_ADC), 8'h7f, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h41);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h80, 1'b1, 16'h0000, 1'b0, 8'h94);
    // 80 - 01 = 7f, half borrow and overflow, N set
    add_step(alu_to_a(ALU_SUB), 8'h01, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h94);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h7f, 1'b1, 16'h0000, 1'b0, 8'h16);
    // 7f - 7f = 00, only Z and N
    add_step(alu_to_a(ALU_SUB), 8'h7f, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h16);
    add_step(read_onto_bus(DS_F, REG_B), 8'h00, 8'h42, 1'b1, 16'h0000, 1'b0, 8'h42);
    // forcing C on and Z off writes F without ld_f, N stays
    c = '0;
    c.flag_force.c = FF_SET;
    c.flag_force.z = FF_CLEAR;
    add_step(c, 8'h00, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h42);
    add_step(read_onto_bus(DS_F, REG_B), 8'h00, 8'h03, 1'b1, 16'h0000, 1'b0, 8'h03);
    // 00 - 01 = ff, borrow out of both nibbles
    add_step(alu_to_a(ALU_SUB), 8'h01, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h03);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'hff, 1'b1, 16'h0000, 1'b0, 8'h93);
    // B 12 -> 13 through the ALU, C is kept
    add_step(inc_reg(REG_B), 8'h00, 8'h12, 1'b1, 16'h0000, 1'b0, 8'h93);
    add_step(read_onto_bus(DS_REG, REG_B), 8'h00, 8'h13, 1'b1, 16'h0000, 1'b0, 8'h01);
    // complement of ff sets H and N on top of the old flags
    add_step(alu_to_a(ALU_CPL), 8'h00, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h01);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h00, 1'b1, 16'h0000, 1'b0, 8'h13);
    // E ff -> 00 gives Z and H, still with C kept
    add_step(load_reg(REG_E), 8'hff, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h13);
    add_step(inc_reg(REG_E), 8'h00, 8'hff, 1'b1, 16'h0000, 1'b0, 8'h13);
    add_step(read_onto_bus(DS_REG, REG_E), 8'h00, 8'h00, 1'b1, 16'h0000, 1'b0, 8'h51);
    // TEMP feeds the ALU while B sits on the bus
    c = '0;
    c.ld_temp = 1'b1;
    add_step(c, 8'h88, 8'h00, 1'b0, 16'h0000, 1'b0, 8'h51);
    add_step(read_onto_bus(DS_TEMP, REG_B), 8'h00, 8'h88, 1'b1, 16'h0000, 1'b0, 8'h51);
    c = alu_to_a(ALU_ADD);
    c.alu_b_temp = 1'b1;
    c.data_src   = DS_REG;
    c.reg_rd     = REG_B;
    add_step(c, 8'h00, 8'h13, 1'b1, 16'h0000, 1'b0, 8'h51);
    add_step(read_onto_bus(DS_A, REG_B), 8'h00, 8'h88, 1'b1, 16'h0000, 1'b0, 8'h80);
  endtask

  // ---------------------------------------------------------------------------
  // checking
  // ---------------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input int idx,
                                 input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp);
    abort_run($sformatf("mismatch %s at step %0d: got 0x%h, expected 0x%h",
                        name, idx, got, exp));
  endtask

  task automatic check_step(input int idx, input step_t s);
    assert (data_out === s.dout)
      else report_mismatch("data_out", idx, addr_w'(data_out), addr_w'(s.dout));
    assert (data_oe === s.doe)
      else report_mismatch("data_oe", idx, addr_w'(data_oe), addr_w'(s.doe));
    assert (addr_out === s.aout)
      else report_mismatch("addr_out", idx, addr_out, s.aout);
    assert (addr_oe === s.aoe)
      else report_mismatch("addr_oe", idx, addr_w'(addr_oe), addr_w'(s.aoe));
    assert (flags === s.fl)
      else report_mismatch("flags", idx, addr_w'(flags), addr_w'(s.fl));
    // the bound properties are sampled on every edge up to this row
    assert (DUT.u_dp_assert.fail_count == 0)
      else abort_run($sformatf("a bound datapath property failed by step %0d", idx));
  endtask

  task automatic wait_reset_release(input int max_cycles);
    int n;
    n = 0;
    while (!arst_n && (n < max_cycles)) begin
      @(posedge clk);
      n++;
    end
    assert (arst_n)
      else abort_run($sformatf("reset was still active after %0d cycles", max_cycles));
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    arst_n  = 1'b0;
    ctrl    = '0;
    data_in = '0;
    build_table();

    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    wait_reset_release(4);

    // each row is applied on a rising edge and checked 2 ns before the next
    foreach (steps[i]) begin
      @(posedge clk);
      ctrl    <= steps[i].ctrl;
      data_in <= steps[i].din;
      #18;
      check_step(i, steps[i]);
    end

    // the edge after the last row still closes the F hold property
    @(posedge clk);
    ctrl    <= '0;
    data_in <= '0;
    #1;
    if (DUT.u_dp_assert.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abort_run("a bound datapath property failed after the last step");
    end
  end

endmodule : z80_datapath_tb

/* source/z80_acc_flags.sv */
module z80_acc_flags
  import z80_alu_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ld_a,
  input  logic                a_from_alu,
  input  logic                ld_f,
  input  logic [data_w-1:0]   alu_result,
  input  logic [data_w-1:0]   bus_d,
  input  flag_t               alu_flags,
  input  flag_force_t         flag_force,
  output logic [data_w-1:0]   acc,
  output flag_t               flags
);

  // resolves one override code against the value the flag would get otherwise
  function automatic logic force_bit(input flag_force_e code, input logic cur);
    logic r;
    case (code)
      FF_SET:   r = 1'b1;
      FF_CLEAR: r = 1'b0;
      default:  r = cur;
    endcase
    return r;
  endfunction

  logic [data_w-1:0] acc_d;
  flag_t             flags_d;
  logic              force_any;
  logic              flags_en;

  // ALU result when the op writes back, raw bus byte for a plain load
  assign acc_d = a_from_alu ? alu_result : bus_d;

  assign force_any = (flag_force.s != FF_KEEP) || (flag_force.z != FF_KEEP) ||
                     (flag_force.h != FF_KEEP) || (flag_force.pv != FF_KEEP) ||
                     (flag_force.n != FF_KEEP) || (flag_force.c != FF_KEEP);

  // a forced flag writes F on its own, the other bits then hold
  assign flags_en = ld_f || force_any;

  always_comb begin
    flags_d    = ld_f ? alu_flags : flags;
    flags_d.s  = force_bit(flag_force.s, flags_d.s);
    flags_d.z  = force_bit(flag_force.z, flags_d.z);
    flags_d.h  = force_bit(flag_force.h, flags_d.h);
    flags_d.pv = force_bit(flag_force.pv, flags_d.pv);
    flags_d.n  = force_bit(flag_force.n, flags_d.n);
    flags_d.c  = force_bit(flag_force.c, flags_d.c);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc   <= '0;
      flags <= '0;
    end else begin
      if (ld_a) begin
        acc <= acc_d;
      end
      if (flags_en) begin
        flags <= flags_d;
      end
    end
  end

endmodule : z80_acc_flags

/* source/z80_alu.sv */
module z80_alu
  import z80_alu_pkg::*;
(
  input  alu_op_e             op,
  input  logic [data_w-1:0]   a,
  input  logic [data_w-1:0]   b,
  input  flag_t               flags_in,
  output logic [data_w-1:0]   result,
  output flag_t               flags_out
);

  // ---------------------------------------------------------------------------
  // shared adder
  // ---------------------------------------------------------------------------

  // every arithmetic op is mapped onto x + y + cin, so one adder serves all
  logic [data_w-1:0] add_x;
  logic [data_w-1:0] add_y;
  logic              add_cin;

  // two nibble stages, bit 4 of each stage is its carry out
  logic [4:0]        lo_sum;
  logic [4:0]        hi_sum;
  logic [data_w-1:0] sum;
  logic              sum_ovf;

  // subtraction adds the complement plus one, so the stage carries come out
  // inverted with respect to the Z80 borrow flags
  always_comb begin
    case (op)
      ALU_ADC: begin
        add_x   = a;
        add_y   = b;
        add_cin = flags_in.c;
      end
      ALU_SUB: begin
        add_x   = a;
        add_y   = ~b;
        add_cin = 1'b1;
      end
      ALU_INC: begin
        add_x   = b;
        add_y   = '0;
        add_cin = 1'b1;
      end
      default: begin
        add_x   = a;
        add_y   = b;
        add_cin = 1'b0;
      end
    endcase
  end

  assign lo_sum = {1'b0, add_x[3:0]} + {1'b0, add_y[3:0]} + {4'd0, add_cin};
  assign hi_sum = {1'b0, add_x[7:4]} + {1'b0, add_y[7:4]} + {4'd0, lo_sum[4]};
  assign sum    = {hi_sum[3:0], lo_sum[3:0]};

  // signed overflow when both addends share a sign that the sum does not
  assign sum_ovf = (add_x[7] == add_y[7]) && (sum[7] != add_x[7]);

  // ---------------------------------------------------------------------------
  // result and flag selection
  // ---------------------------------------------------------------------------

  always_comb begin
    // flags not touched by an op keep their incoming value
    flags_out = flags_in;
    result    = b;

    case (op)
      ALU_ADD, ALU_ADC: begin
        result       = sum;
        flags_out.s  = sum[7];
        flags_out.z  = (sum == '0);
        flags_out.h  = lo_sum[4];
        flags_out.pv = sum_ovf;
        flags_out.n  = 1'b0;
        flags_out.c  = hi_sum[4];
      end
      ALU_SUB: begin
        result       = sum;
        flags_out.s  = sum[7];
        flags_out.z  = (sum == '0);
        flags_out.h  = ~lo_sum[4];
        flags_out.pv = sum_ovf;
        flags_out.n  = 1'b1;
        flags_out.c  = ~hi_sum[4];
      end
      // increment leaves C alone, so multi-byte counts can chain on it
      ALU_INC: begin
        result       = sum;
        flags_out.s  = sum[7];
        flags_out.z  = (sum == '0);
        flags_out.h  = lo_sum[4];
        flags_out.pv = sum_ovf;
        flags_out.n  = 1'b0;
      end
      ALU_CPL: begin
        result      = ~a;
        flags_out.h = 1'b1;
        flags_out.n = 1'b1;
      end
      // PASS_B and the unused codes hand the operand through untouched
      default: begin
        result = b;
      end
    endcase
  end

endmodule : z80_alu

/* source/z80_alu_pkg.sv */
// ---------------------------------------------------------------------------
// arithmetic side of the datapath: operand width, ALU opcodes and flags
// ---------------------------------------------------------------------------
package z80_alu_pkg;

  // every data byte in the core is this wide
  localparam int unsigned data_w = 8;

  // 8-bit ALU operations, encoded in three bits
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_ADC    = 3'd1,
    ALU_SUB    = 3'd2,
    ALU_INC    = 3'd3,
    ALU_CPL    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // flag register in Z80 bit order, bit 7 down to bit 0
  // f5 and f3 are the undocumented copies, they are only carried along
  typedef struct packed {
    logic s;
    logic z;
    logic f5;
    logic h;
    logic f3;
    logic pv;
    logic n;
    logic c;
  } flag_t;

  // per-flag override code, zero means the flag follows the normal path
  typedef enum logic [1:0] {
    FF_KEEP  = 2'b00,
    FF_CLEAR = 2'b10,
    FF_SET   = 2'b11
  } flag_force_e;

  // one override code per architectural flag
  typedef struct packed {
    flag_force_e s;
    flag_force_e z;
    flag_force_e h;
    flag_force_e pv;
    flag_force_e n;
    flag_force_e c;
  } flag_force_t;

endpackage : z80_alu_pkg

/* source/z80_bus_pkg.sv */
// ---------------------------------------------------------------------------
// bus side of the datapath: selectors and the per-cycle control word
// ---------------------------------------------------------------------------
package z80_bus_pkg;

  import z80_alu_pkg::*;

  // width of the address bus and of every register pair
  localparam int unsigned addr_w = 16;

  // number of byte registers held in the register file
  localparam int unsigned num_regs = 10;

  // byte registers, ordered so that a pair is {2p, 2p+1} with the high byte even
  typedef enum logic [3:0] {
    REG_B   = 4'd0,
    REG_C   = 4'd1,
    REG_D   = 4'd2,
    REG_E   = 4'd3,
    REG_H   = 4'd4,
    REG_L   = 4'd5,
    REG_SPH = 4'd6,
    REG_SPL = 4'd7,
    REG_PCH = 4'd8,
    REG_PCL = 4'd9
  } reg_sel_e;

  // register pairs, the code doubled gives the index of the high byte
  typedef enum logic [2:0] {
    PAIR_BC = 3'd0,
    PAIR_DE = 3'd1,
    PAIR_HL = 3'd2,
    PAIR_SP = 3'd3,
    PAIR_PC = 3'd4
  } pair_sel_e;

  // who drives the internal data bus, DS_NONE lets data_in through
  typedef enum logic [2:0] {
    DS_NONE = 3'd0,
    DS_A    = 3'd1,
    DS_F    = 3'd2,
    DS_REG  = 3'd3,
    DS_TEMP = 3'd4
  } data_src_e;

  // who drives the internal address bus
  typedef enum logic [1:0] {
    AS_NONE = 2'd0,
    AS_MAR  = 2'd1,
    AS_PAIR = 2'd2
  } addr_src_e;

  // one control word per clock from the control unit, 44 bits in all
  // an all-zero word is a no-operation cycle
  typedef struct packed {
    data_src_e   data_src;
    addr_src_e   addr_src;
    reg_sel_e    reg_rd;
    pair_sel_e   pair_rd;
    logic        reg_wr_en;
    reg_sel_e    reg_wr;
    logic        pair_wr_en;
    pair_sel_e   pair_wr;
    logic        ld_a;
    logic        a_from_alu;
    logic        ld_f;
    alu_op_e     alu_op;
    logic        alu_b_temp;
    flag_force_t flag_force;
    logic        ld_temp;
    logic        ld_marh_data;
    logic        ld_marl_data;
    logic        ld_mar_addr;
  } dp_ctrl_t;

endpackage : z80_bus_pkg

/* source/z80_datapath.sv */
module z80_datapath
  import z80_alu_pkg::*;
  import z80_bus_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  dp_ctrl_t            ctrl,
  input  logic [data_w-1:0]   data_in,
  output logic [data_w-1:0]   data_out,
  output logic                data_oe,
  output logic [addr_w-1:0]   addr_out,
  output logic                addr_oe,
  output flag_t               flags
);

  // ---------------------------------------------------------------------------
  // internal buses and block outputs
  // ---------------------------------------------------------------------------

  logic [data_w-1:0] data_bus;
  logic [addr_w-1:0] addr_bus;

  logic [data_w-1:0] byte_q;
  logic [addr_w-1:0] pair_q;
  logic [data_w-1:0] acc;
  logic [data_w-1:0] alu_b;
  logic [data_w-1:0] alu_result;
  flag_t             alu_flags;

  // byte loads into the register file take the ALU result on a write-back,
  // so a register increment fits in one cycle with the register on the bus
  logic [data_w-1:0] reg_byte_d;

  logic [data_w-1:0] temp_q;
  logic [addr_w-1:0] mar_q;

  // ---------------------------------------------------------------------------
  // bus arbitration
  // ---------------------------------------------------------------------------

  // one selector per bus, so two drivers can never meet on it
  // with no internal driver the bus carries the external data input
  always_comb begin
    case (ctrl.data_src)
      DS_A: begin
        data_bus = acc;
        data_oe  = 1'b1;
      end
      DS_F: begin
        data_bus = flags;
        data_oe  = 1'b1;
      end
      DS_REG: begin
        data_bus = byte_q;
        data_oe  = 1'b1;
      end
      DS_TEMP: begin
        data_bus = temp_q;
        data_oe  = 1'b1;
      end
      default: begin
        data_bus = data_in;
        data_oe  = 1'b0;
      end
    endcase
  end

  // the address bus is idle at zero when nothing drives it
  always_comb begin
    case (ctrl.addr_src)
      AS_MAR: begin
        addr_bus = mar_q;
        addr_oe  = 1'b1;
      end
      AS_PAIR: begin
        addr_bus = pair_q;
        addr_oe  = 1'b1;
      end
      default: begin
        addr_bus = '0;
        addr_oe  = 1'b0;
      end
    endcase
  end

  // external outputs sit at zero whenever their enable is low
  assign data_out = data_oe ? data_bus : '0;
  assign addr_out = addr_bus;

  // ---------------------------------------------------------------------------
  // TEMP and MAR
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      temp_q <= '0;
      mar_q  <= '0;
    end else begin
      if (ctrl.ld_temp) begin
        temp_q <= data_bus;
      end
      // a whole-word load from the address bus wins over the byte loads
      if (ctrl.ld_mar_addr) begin
        mar_q <= addr_bus;
      end else begin
        if (ctrl.ld_marh_data) begin
          mar_q[addr_w-1:data_w] <= data_bus;
        end
        if (ctrl.ld_marl_data) begin
          mar_q[data_w-1:0] <= data_bus;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // datapath blocks
  // ---------------------------------------------------------------------------

  assign reg_byte_d = ctrl.a_from_alu ? alu_result : data_bus;

  z80_regfile u_regfile (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_rd     (ctrl.reg_rd),
    .pair_rd    (ctrl.pair_rd),
    .reg_wr_en  (ctrl.reg_wr_en),
    .reg_wr     (ctrl.reg_wr),
    .byte_d     (reg_byte_d),
    .pair_wr_en (ctrl.pair_wr_en),
    .pair_wr    (ctrl.pair_wr),
    .pair_d     (addr_bus),
    .byte_q     (byte_q),
    .pair_q     (pair_q)
  );

  // TEMP lets the ALU take a latched operand while the bus is busy elsewhere
  assign alu_b = ctrl.alu_b_temp ? temp_q : data_bus;

  z80_alu u_alu (
    .op        (ctrl.alu_op),
    .a         (acc),
    .b         (alu_b),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  z80_acc_flags u_acc_flags (
    .clk        (clk),
    .arst_n     (arst_n),
    .ld_a       (ctrl.ld_a),
    .a_from_alu (ctrl.a_from_alu),
    .ld_f       (ctrl.ld_f),
    .alu_result (alu_result),
    .bus_d      (data_bus),
    .alu_flags  (alu_flags),
    .flag_force (ctrl.flag_force),
    .acc        (acc),
    .flags      (flags)
  );

endmodule : z80_datapath

/* source/z80_regfile.sv */
module z80_regfile
  import z80_alu_pkg::*;
  import z80_bus_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  reg_sel_e            reg_rd,
  input  pair_sel_e           pair_rd,
  input  logic                reg_wr_en,
  input  reg_sel_e            reg_wr,
  input  logic [data_w-1:0]   byte_d,
  input  logic                pair_wr_en,
  input  pair_sel_e           pair_wr,
  input  logic [addr_w-1:0]   pair_d,
  output logic [data_w-1:0]   byte_q,
  output logic [addr_w-1:0]   pair_q
);

  // ---------------------------------------------------------------------------
  // storage
  // ---------------------------------------------------------------------------

  // B, C, D, E, H, L, SPH, SPL, PCH, PCL in selector order
  logic [data_w-1:0] regs [num_regs];

  // next value and load enable per byte
  logic [data_w-1:0]   wr_d [num_regs];
  logic [num_regs-1:0] wr_en;

  // byte indices of the pair halves, high byte at the even slot
  logic [3:0] wr_hi_idx;
  logic [3:0] wr_lo_idx;
  logic [3:0] rd_hi_idx;
  logic [3:0] rd_lo_idx;

  assign wr_hi_idx = {pair_wr, 1'b0};
  assign wr_lo_idx = {pair_wr, 1'b1};
  assign rd_hi_idx = {pair_rd, 1'b0};
  assign rd_lo_idx = {pair_rd, 1'b1};

  // ---------------------------------------------------------------------------
  // read ports
  // ---------------------------------------------------------------------------

  // both ports are purely combinational, so a read sees the value stored at
  // the last edge and not a load that is happening in the same cycle
  always_comb begin
    if (reg_rd <= REG_PCL) begin
      byte_q = regs[reg_rd];
    end else begin
      byte_q = '0;
    end
  end

  // a pair goes out high byte first, as the Z80 puts it on the address bus
  always_comb begin
    if (pair_rd <= PAIR_PC) begin
      pair_q = {regs[rd_hi_idx], regs[rd_lo_idx]};
    end else begin
      pair_q = '0;
    end
  end

  // ---------------------------------------------------------------------------
  // write decode
  // ---------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_regs; i++) begin
      wr_en[i] = 1'b0;
      wr_d[i]  = regs[i];
    end

    // a pair load splits the address bus word over the two halves
    if (pair_wr_en && (pair_wr <= PAIR_PC)) begin
      wr_en[wr_hi_idx] = 1'b1;
      wr_d[wr_hi_idx]  = pair_d[addr_w-1:data_w];
      wr_en[wr_lo_idx] = 1'b1;
      wr_d[wr_lo_idx]  = pair_d[data_w-1:0];
    end

    // byte and pair loads of the same register in one cycle are illegal,
    // if it happens anyway the byte load is the one that lands
    if (reg_wr_en && (reg_wr <= REG_PCL)) begin
      wr_en[reg_wr] = 1'b1;
      wr_d[reg_wr]  = byte_d;
    end
  end

  // every byte clears on reset so the core starts from a known state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_regs; i++) begin
        if (wr_en[i]) begin
          regs[i] <= wr_d[i];
        end
      end
    end
  end

endmodule : z80_regfile
